// ==== hdl/nes_cart_pkg.sv ====
// Shared definitions for the cartridge image loader and controller ports
// Address map, iNES header constants, loader states and bus structs
`default_nettype none

package nes_cart_pkg;

	// Cartridge memory map
	localparam int ADDR_W = 22;
	localparam logic [ADDR_W-1:0] CHR_BASE = 22'h200000;  // CHR ROM follows 2 MB of PRG space

	// Page counts in the header are in 16 KB (PRG) and 8 KB (CHR) units
	localparam int PRG_PAGE_BITS = 14;
	localparam int CHR_PAGE_BITS = 13;

	// iNES signature "NES" followed by MS-DOS end of file
	localparam logic [7:0] INES_SIG0 = 8'h4E;
	localparam logic [7:0] INES_SIG1 = 8'h45;
	localparam logic [7:0] INES_SIG2 = 8'h53;
	localparam logic [7:0] INES_SIG3 = 8'h1A;
	localparam int HDR_BYTES = 16;

	// Controller serial ports
	localparam int PAD_FRAME_W = 24;
	localparam int NUM_PADS = 2;
	localparam logic [7:0] MTAP_SIG_A = 8'h08;  // Four Score signature, port 1
	localparam logic [7:0] MTAP_SIG_B = 8'h04;  // Four Score signature, port 2

	typedef enum logic [2:0] {
		ld_header,
		ld_prg,
		ld_chr,
		ld_done,
		ld_error
	} loader_state_e;

	// Raw header as captured, byte 0 in the lowest slot
	typedef logic [HDR_BYTES-1:0][7:0] ines_header_t;

	// One byte write into cartridge memory
	typedef struct packed {
		logic              valid;
		logic [ADDR_W-1:0] addr;
		logic [7:0]        data;
	} mem_write_t;

	// Decoded cartridge configuration handed to the mapper logic
	typedef struct packed {
		logic [7:0] submapper;    // NES 2.0 byte 8, zero otherwise
		logic       four_screen;
		logic       chr_ram;      // No CHR ROM in the image
		logic       mirroring;    // Already XORed with the invert switch
		logic [2:0] chr_size;
		logic [2:0] prg_size;
		logic [7:0] mapper;
	} mapper_flags_t;

	// Host joystick byte, bit 7 down to bit 0
	typedef struct packed {
		logic start;
		logic select;
		logic b;
		logic a;
		logic up;
		logic down;
		logic left;
		logic right;
	} pad_buttons_t;

	typedef logic [PAD_FRAME_W-1:0] pad_frame_t;

endpackage

`default_nettype wire

// ==== hdl/ines_loader_fsm.sv ====
// iNES image loader
// Captures the 16-byte header, checks it, then streams PRG and CHR bytes
// into cartridge memory and reports done or error
`timescale 1ns/1ps
`default_nettype none

module ines_loader_fsm import nes_cart_pkg::*; (
	input  wire logic         clk,
	input  wire logic         reset,
	input  wire logic         downloading,
	input  wire logic [7:0]   in_byte,
	input  wire logic         in_strobe,
	input  wire logic [7:0]   prg_pages,
	input  wire logic [7:0]   chr_pages,
	output mem_write_t        mem_wr,
	output ines_header_t      header_bytes,
	output logic              hdr_done,
	output logic              done,
	output logic              error
);

	loader_state_e     state;
	logic [3:0]        hdr_cnt;
	ines_header_t      hdr_q;
	logic [ADDR_W-1:0] byte_cnt;   // Bytes still expected in the current region
	logic [ADDR_W-1:0] addr_q;
	logic              downloading_q;
	logic              dl_rise;
	logic              dl_fall;
	logic              hdr_last;
	logic              sig_ok;
	logic              last_byte;

	assign dl_rise = downloading & ~downloading_q;
	assign dl_fall = ~downloading & downloading_q;
	assign hdr_last = in_strobe && (hdr_cnt == 4'(HDR_BYTES - 1));

	// Trainers are not supported, so a set bit 2 in flags 6 counts as a bad header
	assign sig_ok = (hdr_q[0] == INES_SIG0) && (hdr_q[1] == INES_SIG1) &&
		(hdr_q[2] == INES_SIG2) && (hdr_q[3] == INES_SIG3) && !hdr_q[6][2];

	always_comb begin
		mem_wr.valid = in_strobe && (state == ld_prg || state == ld_chr) && (byte_cnt != '0);
		mem_wr.addr = addr_q;
		mem_wr.data = in_byte;
	end

	assign last_byte = mem_wr.valid && (byte_cnt == ADDR_W'(1));
	assign header_bytes = hdr_q;

	// Header bytes are plain storage
	always_ff @(posedge clk) begin
		if (in_strobe && (state == ld_header || dl_rise)) begin
			hdr_q[dl_rise ? 4'd0 : hdr_cnt] <= in_byte;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ld_header;
			hdr_cnt <= '0;
			byte_cnt <= '0;
			addr_q <= '0;
			downloading_q <= 1'b0;
			hdr_done <= 1'b0;
			done <= 1'b0;
			error <= 1'b0;
		end else begin
			downloading_q <= downloading;
			hdr_done <= 1'b0;
			if (dl_rise) begin
				// New image, a byte arriving with the rise is header byte 0
				state <= ld_header;
				hdr_cnt <= in_strobe ? 4'd1 : 4'd0;
				byte_cnt <= '0;
				addr_q <= '0;
				done <= 1'b0;
				error <= 1'b0;
			end else begin
				case (state)
					ld_header: begin
						if (in_strobe) begin
							hdr_cnt <= hdr_cnt + 4'd1;
						end
						if (hdr_last) begin
							if (sig_ok) begin
								state <= ld_prg;
								addr_q <= '0;
								byte_cnt <= ADDR_W'(prg_pages) << PRG_PAGE_BITS;
								hdr_done <= 1'b1;
							end else begin
								state <= ld_error;
								done <= 1'b1;
								error <= 1'b1;
							end
						end
					end
					ld_prg: begin
						if (mem_wr.valid) begin
							byte_cnt <= byte_cnt - ADDR_W'(1);
							addr_q <= addr_q + ADDR_W'(1);
						end
						// Empty PRG region only happens with a zero page count
						if (last_byte || byte_cnt == '0) begin
							if (chr_pages == '0) begin
								state <= ld_done;   // CHR RAM cartridge
								done <= 1'b1;
							end else begin
								state <= ld_chr;
								addr_q <= CHR_BASE;
								byte_cnt <= ADDR_W'(chr_pages) << CHR_PAGE_BITS;
							end
						end
					end
					ld_chr: begin
						if (mem_wr.valid) begin
							byte_cnt <= byte_cnt - ADDR_W'(1);
							addr_q <= addr_q + ADDR_W'(1);
						end
						if (last_byte) begin
							state <= ld_done;
							done <= 1'b1;
						end
					end
					default: ;  // Trailing bytes are dropped until the next download
				endcase

				// Download ended early, a partial header is an error
				if (dl_fall && (state == ld_prg || state == ld_chr) && !last_byte) begin
					state <= ld_done;
					done <= 1'b1;
				end
				if (dl_fall && state == ld_header && hdr_cnt != '0 && !hdr_last) begin
					state <= ld_error;
					done <= 1'b1;
					error <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/ines_flags_decode.sv ====
// iNES header decoder
// Derives page counts, size codes and mapper number from the raw header
// and latches the mapper flags once the header is accepted
`timescale 1ns/1ps
`default_nettype none

module ines_flags_decode import nes_cart_pkg::*; (
	input  wire logic          clk,
	input  wire logic          reset,
	input  wire ines_header_t  header_bytes,
	input  wire logic          hdr_done,
	input  wire logic          invert_mirroring,
	output logic [7:0]         prg_pages,
	output logic [7:0]         chr_pages,
	output mapper_flags_t      mapper_flags
);

	logic          is_nes20;
	logic          is_dirty;
	mapper_flags_t flags_next;

	// Log2 of the page count rounded up, 0 and 1 both give 0
	function automatic logic [2:0] size_code(input logic [7:0] pages);
		logic [2:0] code;
		code = 3'd0;
		for (int i = 0; i < 7; i++) begin
			if (pages > (8'd1 << i)) begin
				code = 3'(i + 1);
			end
		end
		return code;
	endfunction

	assign prg_pages = header_bytes[4];
	assign chr_pages = header_bytes[5];

	assign is_nes20 = (header_bytes[7][3:2] == 2'b10);
	// Old dumps often carry junk in bytes 8 to 15, including a bogus upper mapper nibble
	assign is_dirty = !is_nes20 && (|header_bytes[15:8]);

	always_comb begin
		flags_next.mapper = {is_dirty ? 4'h0 : header_bytes[7][7:4], header_bytes[6][7:4]};
		flags_next.prg_size = size_code(prg_pages);
		flags_next.chr_size = size_code(chr_pages);
		flags_next.mirroring = header_bytes[6][0] ^ invert_mirroring;
		flags_next.chr_ram = (chr_pages == 8'd0);
		flags_next.four_screen = header_bytes[6][3];
		flags_next.submapper = is_nes20 ? header_bytes[8] : 8'h00;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			mapper_flags <= '0;
		end else if (hdr_done) begin
			mapper_flags <= flags_next;  // Held until the next accepted header
		end
	end

endmodule

`default_nettype wire

// ==== hdl/joypad_frame_builder.sv ====
// Controller frame builder
// Puts host buttons into console serial order and forms the 24-bit frame
// of each port, with optional port swap and Four Score signatures
`timescale 1ns/1ps
`default_nettype none

module joypad_frame_builder import nes_cart_pkg::*; (
	input  wire pad_buttons_t joy [4],
	input  wire logic         swap,
	input  wire logic         multitap,
	output pad_frame_t        frames [NUM_PADS]
);

	pad_buttons_t near_pad [NUM_PADS];  // Pads plugged straight into the ports

	// Bit 0 is shifted out first: A, B, Select, Start, Up, Down, Left, Right
	function automatic logic [7:0] to_serial(input pad_buttons_t p);
		return {p.right, p.left, p.down, p.up, p.start, p.select, p.b, p.a};
	endfunction

	function automatic logic [7:0] mtap_sig(input int port);
		return (port == 0) ? MTAP_SIG_A : MTAP_SIG_B;
	endfunction

	always_comb begin
		for (int i = 0; i < NUM_PADS; i++) begin
			near_pad[i] = swap ? joy[NUM_PADS - 1 - i] : joy[i];  // Swap only touches pads 0 and 1
		end
	end

	always_comb begin
		for (int i = 0; i < NUM_PADS; i++) begin
			if (multitap) begin
				frames[i] = {mtap_sig(i), to_serial(joy[i + 2]), to_serial(near_pad[i])};
			end else begin
				frames[i] = {16'h0000, to_serial(near_pad[i])};
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/joypad_port.sv ====
// One controller serial port
// Loads a frame while the console strobes and shifts on joypad clock falls
`timescale 1ns/1ps
`default_nettype none

module joypad_port import nes_cart_pkg::*; (
	input  wire logic       clk,
	input  wire logic       reset,
	input  wire pad_frame_t frame,
	input  wire logic       strobe,
	input  wire logic       pad_clock,
	output logic            pad_data
);

	pad_frame_t shift_q;
	logic       pad_clock_q;
	logic       clock_fall;

	assign clock_fall = !pad_clock && pad_clock_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			shift_q <= '0;
			pad_clock_q <= 1'b0;
		end else begin
			pad_clock_q <= pad_clock;
			if (strobe) begin
				shift_q <= frame;
			end
			if (clock_fall) begin
				shift_q <= {1'b0, shift_q[PAD_FRAME_W-1:1]};  // Reads 0 once the frame is spent
			end
		end
	end

	assign pad_data = shift_q[0];

endmodule

`default_nettype wire

// ==== hdl/nes_cart_io_top.sv ====
// Cartridge loader and controller port top level
// Ties the iNES loader to its header decoder and drives the serial ports
`timescale 1ns/1ps
`default_nettype none

module nes_cart_io_top import nes_cart_pkg::*; (
	input  wire logic                clk,
	input  wire logic                reset,
	input  wire logic                downloading,
	input  wire logic [7:0]          in_byte,
	input  wire logic                in_strobe,
	input  wire logic                invert_mirroring,
	input  wire pad_buttons_t        joy [4],
	input  wire logic                swap,
	input  wire logic                multitap,
	input  wire logic                joypad_strobe,
	input  wire logic [NUM_PADS-1:0] joypad_clock,
	output mem_write_t               mem_wr,
	output mapper_flags_t            mapper_flags,
	output logic                     done,
	output logic                     error,
	output logic [NUM_PADS-1:0]      pad_data
);

	ines_header_t header_bytes;
	logic         hdr_done;
	logic [7:0]   prg_pages;
	logic [7:0]   chr_pages;
	pad_frame_t   frames [NUM_PADS];

	ines_loader_fsm i_ines_loader_fsm (
		.clk          (clk),
		.reset        (reset),
		.downloading  (downloading),
		.in_byte      (in_byte),
		.in_strobe    (in_strobe),
		.prg_pages    (prg_pages),
		.chr_pages    (chr_pages),
		.mem_wr       (mem_wr),
		.header_bytes (header_bytes),
		.hdr_done     (hdr_done),
		.done         (done),
		.error        (error)
	);

	// Page counts flow back to the loader for its byte counters
	ines_flags_decode i_ines_flags_decode (
		.clk              (clk),
		.reset            (reset),
		.header_bytes     (header_bytes),
		.hdr_done         (hdr_done),
		.invert_mirroring (invert_mirroring),
		.prg_pages        (prg_pages),
		.chr_pages        (chr_pages),
		.mapper_flags     (mapper_flags)
	);

	joypad_frame_builder i_joypad_frame_builder (
		.joy      (joy),
		.swap     (swap),
		.multitap (multitap),
		.frames   (frames)
	);

	for (genvar i = 0; i < NUM_PADS; i++) begin : g_port
		joypad_port i_joypad_port (
			.clk       (clk),
			.reset     (reset),
			.frame     (frames[i]),
			.strobe    (joypad_strobe),   // Shared by both ports
			.pad_clock (joypad_clock[i]),
			.pad_data  (pad_data[i])
		);
	end

endmodule

`default_nettype wire

// ==== tb/nes_cart_io_assertions.sv ====
// Loader and controller port protocol checks
// Bound into ines_loader_fsm and joypad_port with unused inputs tied off
`timescale 1ns/1ps
`default_nettype none

module nes_cart_io_assertions (
	input wire logic clk,
	input wire logic reset,
	input wire logic in_strobe,
	input wire logic dl_active,
	input wire logic wr_valid,
	input wire logic done,
	input wire logic error,
	input wire logic pad_data
);

	int unsigned fail_count = 0;

	assert property (@(posedge clk) disable iff (reset) wr_valid |-> in_strobe && dl_active)
	else begin
		fail_count++;
		$error("memory write without a byte strobe during a download");
	end

	// A rejected header ends the load in the same cycle
	assert property (@(posedge clk) disable iff (reset) $rose(error) |-> $rose(done))
	else begin
		fail_count++;
		$error("error rose without done");
	end

	// Once done is set the loader ignores further bytes
	assert property (@(posedge clk) disable iff (reset) done |-> !wr_valid)
	else begin
		fail_count++;
		$error("memory write after the image was complete");
	end

	assert property (@(posedge clk) $fell(reset) |-> !pad_data)
	else begin
		fail_count++;
		$error("controller data not cleared by reset");
	end

endmodule

bind ines_loader_fsm nes_cart_io_assertions i_loader_assertions (
	.clk       (clk),
	.reset     (reset),
	.in_strobe (in_strobe),
	.dl_active (downloading_q),
	.wr_valid  (mem_wr.valid),
	.done      (done),
	.error     (error),
	.pad_data  (1'b0)
);

bind joypad_port nes_cart_io_assertions i_port_assertions (
	.clk       (clk),
	.reset     (reset),
	.in_strobe (1'b0),
	.dl_active (1'b0),
	.wr_valid  (1'b0),
	.done      (1'b0),
	.error     (1'b0),
	.pad_data  (pad_data)
);

`default_nettype wire

// ==== tb/tb_nes_cart_io.sv ====
// Testbench for the cartridge loader and controller port top level
// Streams random iNES images and pad states, checks writes, flags and serial bits
`timescale 1ns/1ps
`default_nettype none

module tb_nes_cart_io import nes_cart_pkg::*; ();

	localparam int NUM_IMAGES = 5;
	localparam int TRAIL_BYTES = 4;   // Sent after done
	localparam int MAX_GAP = 3;       // Idle cycles before a strobe
	localparam int MAX_IMAGE = 16 + 2 * 16384 + 8192 + TRAIL_BYTES;
	localparam int PAD_ROUNDS = 8;
	localparam int PAD_CYCLES = PAD_ROUNDS * (2 + NUM_PADS * 3 * (PAD_FRAME_W + 2));
	localparam int WATCHDOG_NS =
		(NUM_IMAGES * MAX_IMAGE * (MAX_GAP + 1) + PAD_CYCLES) * 8 + 20000;

	logic                clk;
	logic                reset;
	logic                downloading;
	logic [7:0]          in_byte;
	logic                in_strobe;
	logic                invert_mirroring;
	pad_buttons_t        joy [4];
	logic                swap;
	logic                multitap;
	logic                joypad_strobe;
	logic [NUM_PADS-1:0] joypad_clock;
	mem_write_t          mem_wr;
	mapper_flags_t       mapper_flags;
	logic                done;
	logic                error;
	logic [NUM_PADS-1:0] pad_data;
	integer              seed = 32'h3b457a9b;
	logic [7:0]          hdr [16];
	logic [7:0]          image [$];

	nes_cart_io_top i_nes_cart_io_top (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("TB FAILED");
		$fatal(1, "watchdog expired");
	end

	task automatic report_mismatch(input string msg);
		$display("MISMATCH at %0t ns: %s", $time, msg);
		$display("TB FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_mem_write(input mem_write_t got, input mem_write_t exp, input int idx);
		if (got.valid !== exp.valid || (exp.valid && got !== exp)) begin
			report_mismatch($sformatf("byte %0d write v=%b a=%h d=%h, expected v=%b a=%h d=%h",
				idx, got.valid, got.addr, got.data, exp.valid, exp.addr, exp.data));
		end
	endtask

	task automatic check_flags(input mapper_flags_t got, input mapper_flags_t exp);
		if (got !== exp) begin
			report_mismatch($sformatf("mapper flags %h, expected %h", got, exp));
		end
	endtask

	task automatic check_pad_bit(input logic got, input logic exp, input int port, input int k);
		if (got !== exp) begin
			report_mismatch($sformatf("port %0d bit %0d is %b, expected %b", port, k, got, exp));
		end
	endtask

	// Smallest code with 2**code >= pages, capped at 7
	function automatic logic [2:0] expected_size(input int pages);
		int code;
		code = 0;
		while (code < 7 && (1 << code) < pages) begin
			code++;
		end
		return 3'(code);
	endfunction

	function automatic mapper_flags_t expected_flags(input logic inv);
		mapper_flags_t f;
		logic          nes20;
		logic          junk;
		nes20 = (hdr[7][3:2] == 2'b10);
		junk = 1'b0;
		for (int i = 8; i < 16; i++) begin
			junk = junk | (hdr[i] != 8'h00);
		end
		f.mapper = {hdr[7][7:4], hdr[6][7:4]};
		if (junk && !nes20) begin
			f.mapper[7:4] = 4'h0;  // Dirty iNES 1.0 header
		end
		f.prg_size = expected_size(hdr[4]);
		f.chr_size = expected_size(hdr[5]);
		f.mirroring = hdr[6][0] ^ inv;
		f.chr_ram = (hdr[5] == 8'h00);
		f.four_screen = hdr[6][3];
		f.submapper = nes20 ? hdr[8] : 8'h00;
		return f;
	endfunction

	// A leaves first, then B, Select, Start, Up, Down, Left, Right
	function automatic logic [7:0] serial_order(input pad_buttons_t p);
		return {p.right, p.left, p.down, p.up, p.start, p.select, p.b, p.a};
	endfunction

	function automatic pad_frame_t expected_frame(input int port);
		pad_buttons_t direct;
		logic [7:0]   sig;
		direct = swap ? joy[1 - port] : joy[port];
		sig = (port == 0) ? 8'h08 : 8'h04;
		if (multitap) begin
			return {sig, serial_order(joy[port + 2]), serial_order(direct)};
		end else begin
			return {16'h0000, serial_order(direct)};
		end
	endfunction

	// kind 0 good, 1 bad signature, 2 trainer; mode 0 NES 2.0, 1 clean, 2 dirty
	task automatic build_image(input int kind, input int mode, output int n_prg, output int n_chr);
		n_prg = 1 + ($unsigned($random(seed)) % 2);
		n_chr = (mode == 1) ? 0 : $unsigned($random(seed)) % 2;
		hdr[0] = 8'h4E;  // "NES" then end of file
		hdr[1] = 8'h45;
		hdr[2] = 8'h53;
		hdr[3] = 8'h1A;
		hdr[4] = 8'(n_prg);
		hdr[5] = 8'(n_chr);
		hdr[6] = 8'($random(seed));
		hdr[6][2] = (kind == 2);
		hdr[7] = 8'($random(seed));
		hdr[7][3:2] = (mode == 0) ? 2'b10 : 2'b00;
		for (int i = 8; i < 16; i++) begin
			hdr[i] = (mode == 1) ? 8'h00 : 8'($random(seed));
		end
		if (mode == 2) begin
			hdr[11][0] = 1'b1;
		end
		if (kind == 1) begin
			hdr[$unsigned($random(seed)) % 4] ^= 8'h20;
		end
		image.delete();
		for (int i = 0; i < 16; i++) begin
			image.push_back(hdr[i]);
		end
		if (kind == 0) begin
			repeat (n_prg * 16384 + n_chr * 8192) image.push_back(8'($random(seed)));
		end
		repeat (TRAIL_BYTES) image.push_back(8'($random(seed)));
	endtask

	task automatic send_byte(input logic [7:0] b, input mem_write_t exp, input int idx);
		repeat ($unsigned($random(seed)) % (MAX_GAP + 1)) @(negedge clk);
		in_byte = b;
		in_strobe = 1'b1;
		#1;
		check_mem_write(mem_wr, exp, idx);
		@(negedge clk);
		in_strobe = 1'b0;
	endtask

	task automatic wait_done(input logic exp_error);
		int cycles;
		cycles = 0;
		while (done !== 1'b1) begin
			@(negedge clk);
			cycles++;
			if (cycles > 16) begin
				$display("Timeout: done did not rise after the last image byte");
				$display("TB FAILED");
				$fatal(1, "loader never finished");
			end
		end
		if (error !== exp_error) begin
			report_mismatch($sformatf("error is %b when done rose, expected %b", error, exp_error));
		end
	endtask

	task automatic run_image(input int kind, input int mode);
		int         n_prg;
		int         n_chr;
		int         prg_end;
		int         chr_end;
		int         last_idx;
		mem_write_t exp;
		build_image(kind, mode, n_prg, n_chr);
		prg_end = 16 + n_prg * 16384;
		chr_end = prg_end + n_chr * 8192;
		last_idx = (kind == 0) ? chr_end - 1 : 15;
		invert_mirroring = 1'($random(seed));
		downloading = 1'b1;
		@(negedge clk);
		for (int idx = 0; idx < image.size(); idx++) begin
			if (idx <= last_idx && done !== 1'b0) begin
				report_mismatch($sformatf("done set before byte %0d of the image", idx));
			end
			exp = '0;
			if (kind == 0 && idx >= 16 && idx < chr_end) begin
				exp.valid = 1'b1;
				exp.addr = (idx < prg_end) ? 22'(idx - 16) : 22'h200000 + 22'(idx - prg_end);
				exp.data = image[idx];
			end
			send_byte(image[idx], exp, idx);
			if (idx == last_idx) begin
				wait_done(kind != 0);
			end
		end
		if (kind == 0) begin
			check_flags(mapper_flags, expected_flags(invert_mirroring));
		end
		downloading = 1'b0;
		repeat (3) @(negedge clk);
	endtask

	task automatic run_pads();
		pad_frame_t exp;
		for (int r = 0; r < PAD_ROUNDS; r++) begin
			for (int j = 0; j < 4; j++) begin
				joy[j] = 8'($random(seed));
			end
			swap = 1'($random(seed));
			multitap = 1'($random(seed));
			joypad_strobe = 1'b1;
			@(negedge clk);
			joypad_strobe = 1'b0;
			@(negedge clk);
			for (int p = 0; p < NUM_PADS; p++) begin
				exp = expected_frame(p);
				check_pad_bit(pad_data[p], exp[0], p, 0);
				for (int k = 1; k < PAD_FRAME_W + 2; k++) begin
					joypad_clock[p] = 1'b1;
					@(negedge clk);
					joypad_clock[p] = 1'b0;
					repeat (2) @(negedge clk);
					check_pad_bit(pad_data[p], (k < PAD_FRAME_W) ? exp[k] : 1'b0, p, k);
				end
			end
		end
	endtask

	initial begin
		mem_write_t  idle;
		int unsigned sva_fails;
		reset = 1'b1;
		downloading = 1'b0;
		in_byte = 8'h00;
		in_strobe = 1'b0;
		invert_mirroring = 1'b0;
		for (int j = 0; j < 4; j++) begin
			joy[j] = '0;
		end
		swap = 1'b0;
		multitap = 1'b0;
		joypad_strobe = 1'b0;
		joypad_clock = '0;
		repeat (5) @(negedge clk);
		reset = 1'b0;
		idle = '0;
		check_mem_write(mem_wr, idle, -1);
		if (done !== 1'b0 || error !== 1'b0) begin
			report_mismatch("done or error set after reset");
		end
		check_pad_bit(pad_data[0], 1'b0, 0, -1);
		check_pad_bit(pad_data[1], 1'b0, 1, -1);

		run_image(0, 0);
		run_image(1, 0);
		run_image(0, 1);
		run_image(2, 2);
		run_image(0, 2);
		run_pads();

		sva_fails = i_nes_cart_io_top.i_ines_loader_fsm.i_loader_assertions.fail_count
			+ i_nes_cart_io_top.g_port[0].i_joypad_port.i_port_assertions.fail_count
			+ i_nes_cart_io_top.g_port[1].i_joypad_port.i_port_assertions.fail_count;
		if (sva_fails == 0) begin
			$display("TB PASSED");
			$finish;
		end else begin
			$display("%0d assertion failures during the run", sva_fails);
			$display("TB FAILED");
			$fatal(1, "assertions failed");
		end
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
hdl/nes_cart_pkg.sv
hdl/ines_loader_fsm.sv
hdl/ines_flags_decode.sv
hdl/joypad_frame_builder.sv
hdl/joypad_port.sv
hdl/nes_cart_io_top.sv
tb/nes_cart_io_assertions.sv
tb/tb_nes_cart_io.sv

// ==== Bender.yml ====
package:
  name: nes_cart_io

sources:
  - files:
      - hdl/nes_cart_pkg.sv
      - hdl/ines_loader_fsm.sv
      - hdl/ines_flags_decode.sv
      - hdl/joypad_frame_builder.sv
      - hdl/joypad_port.sv
      - hdl/nes_cart_io_top.sv
  - target: test
    files:
      - tb/nes_cart_io_assertions.sv
      - tb/tb_nes_cart_io.sv
